//--- rtl/vgafbFifoPkg.sv
// FIFO geometry localparams, pointer type and Gray encoding function

package vgafbFifoPkg;

    // ======================================================================
    // Buffer geometry
    // ======================================================================
    localparam int addrWidth = 4;
    localparam int fifoDepth = 1 << addrWidth;

    // One extra bit above the address tells a wrapped pointer apart
    typedef logic [addrWidth:0] ptrT;

    // Binary to reflected Gray code
    // Only one bit changes per increment, safe to resample in the other domain
    function automatic ptrT bin2gray(input ptrT bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

//--- rtl/vgafbPixelPkg.sv
// Pixel type, FIFO word union, source request and scanout output structs

package vgafbPixelPkg;

    // ======================================================================
    // Word and field widths
    // ======================================================================
    localparam int dataWidth    = 32;
    localparam int lineNumWidth = 12;

    // RGB565 pixel, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565T;

    // Data view, one base pixel, the second is its inverse
    typedef struct packed {
        logic        isMarker;
        logic [14:0] pad;
        rgb565T      pix;
    } pixelWordT;

    // End-of-line view
    typedef struct packed {
        logic                    isMarker;
        logic [18:0]             pad;
        logic [lineNumWidth-1:0] lineNum;
    } markerWordT;

    // Bit 31 is isMarker in both views
    typedef union packed {
        pixelWordT  pixels;
        markerWordT marker;
    } fifoWordT;

    // Source side of the four-phase handshake
    typedef struct packed {
        logic     req;
        fifoWordT word;
    } srcReqT;

    // Display side output, all fields registered
    typedef struct packed {
        logic                    pixValid;
        rgb565T                  pix;
        logic                    lineEnd;
        logic [lineNumWidth-1:0] lineNum;
    } pixOutT;

endpackage

//--- rtl/vgafbGrayCounter.sv
// Binary pointer counter with a registered Gray-coded copy and count enable
`timescale 1ns/1ps

module vgafbGrayCounter
    import vgafbFifoPkg::*;
(
    // Domain clock, tied to RClk on the read side
    input  logic WClk,
    input  logic PresetEmpty,
    // Advance by one entry
    input  logic en,
    // Gray form, crosses to the other domain
    output ptrT  grayPtr,
    // Binary form, low bits address the memory
    output ptrT  binPtr
);

    ptrT binNext;

    // Next binary value
    assign binNext = binPtr + ptrT'(en);

    // ======================================================================
    // Pointer registers
    // ======================================================================
    // Gray copy is registered from binNext, so both forms
    // always change on the same edge and never glitch
    always_ff @(posedge WClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            binPtr  <= '0;
            grayPtr <= '0;
        end else begin
            binPtr  <= binNext;
            grayPtr <= bin2gray(binNext);
        end
    end

endmodule

//--- rtl/vgafbAsFifo.sv
// Dual-clock FIFO: word memory, Gray pointers, two-flop synchronizers, full/empty flags
`timescale 1ns/1ps

module vgafbAsFifo
    import vgafbFifoPkg::*, vgafbPixelPkg::*;
(
    input  logic     WClk,
    input  logic     RClk,
    input  logic     PresetEmpty,
    // Write port, WClk domain
    input  logic     wrEn,
    input  fifoWordT wrWord,
    output logic     full,
    // Read port, RClk domain
    input  logic     rdEn,
    output fifoWordT rdWord,
    output logic     empty
);

    logic [dataWidth-1:0] mem [fifoDepth];

    ptrT  wBin, wGray, wBinNext, wGrayNext;
    ptrT  rBin, rGray, rBinNext, rGrayNext;
    ptrT  wGraySync1, wGraySync2;
    ptrT  rGraySync1, rGraySync2;
    logic wrInc, rdInc;

    // Pointer moves only on an accepted access
    assign wrInc = wrEn & ~full;
    assign rdInc = rdEn & ~empty;

    // ======================================================================
    // Storage
    // ======================================================================
    // Combinational read at the read pointer
    assign rdWord = mem[rBin[addrWidth-1:0]];

    always_ff @(posedge WClk) begin
        if (wrInc) begin
            mem[wBin[addrWidth-1:0]] <= wrWord;
        end
    end

    // ======================================================================
    // Pointers, one counter per domain
    // ======================================================================
    vgafbGrayCounter i_wrPtr (
        .WClk        (WClk),
        .PresetEmpty (PresetEmpty),
        .en          (wrInc),
        .grayPtr     (wGray),
        .binPtr      (wBin)
    );

    vgafbGrayCounter i_rdPtr (
        .WClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .en          (rdInc),
        .grayPtr     (rGray),
        .binPtr      (rBin)
    );

    // Look-ahead values for the flag compares
    assign wBinNext  = wBin + ptrT'(wrInc);
    assign wGrayNext = bin2gray(wBinNext);
    assign rBinNext  = rBin + ptrT'(rdInc);
    assign rGrayNext = bin2gray(rBinNext);

    // Write pointer into the read domain
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            wGraySync1 <= '0;
            wGraySync2 <= '0;
        end else begin
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
        end
    end

    // Read pointer into the write domain
    always_ff @(posedge WClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            rGraySync1 <= '0;
            rGraySync2 <= '0;
        end else begin
            rGraySync1 <= rGray;
            rGraySync2 <= rGraySync1;
        end
    end

    // ======================================================================
    // Flags
    // ======================================================================
    // Empty when the next read pointer catches the synchronized write pointer
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            empty <= 1'b1;
        end else begin
            empty <= (rGrayNext == wGraySync2);
        end
    end

    // Full when one lap ahead, in Gray that flips the top two bits only
    always_ff @(posedge WClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            full <= 1'b0;
        end else begin
            full <= (wGrayNext == {~rGraySync2[addrWidth:addrWidth-1],
                                   rGraySync2[addrWidth-2:0]});
        end
    end

    // Producer must respect the registered full flag
    assert property (@(posedge WClk) disable iff (PresetEmpty) wrEn |-> !full)
        else $error("FIFO write while full");

    // Consumer must respect the registered empty flag
    assert property (@(posedge RClk) disable iff (PresetEmpty) rdEn |-> !empty)
        else $error("FIFO read while empty");

    // Both views of the fill level never collapse at once
    assert property (@(posedge WClk) disable iff (PresetEmpty) !(full && empty))
        else $error("FIFO full and empty together");

endmodule

//--- rtl/vgafbFetch.sv
// Memory-side producer: four-phase req/ack slave writing source words into the FIFO
`timescale 1ns/1ps

module vgafbFetch
    import vgafbPixelPkg::*;
(
    input  logic     WClk,
    input  logic     PresetEmpty,
    // Source request, word held stable while req or ack is high
    input  srcReqT   src,
    output logic     srcAck,
    // FIFO write port
    output logic     wrEn,
    output fifoWordT wrWord,
    input  logic     full
);

    // ======================================================================
    // Handshake FSM
    // ======================================================================
    // srcAck low   idle, waiting for req and room in the FIFO
    // srcAck high  word taken, waiting for the source to drop req

    // Write on the edge that raises ack, one write per handshake
    // Full holds the source off until the reader frees an entry
    assign wrEn = ~srcAck & src.req & ~full;

    // Source keeps the word stable, FIFO samples it on the accepting edge
    assign wrWord = src.word;

    always_ff @(posedge WClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            srcAck <= 1'b0;
        end else begin
            case (srcAck)
                1'b0: begin
                    // Accept, ack follows req by one edge
                    if (wrEn) begin
                        srcAck <= 1'b1;
                    end
                end
                default: begin
                    // Release once req is seen low
                    if (!src.req) begin
                        srcAck <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Ack only ever answers a live request
    assert property (@(posedge WClk) disable iff (PresetEmpty)
        $rose(srcAck) |-> $past(src.req))
        else $error("srcAck raised without a request");

endmodule

//--- rtl/vgafbScanout.sv
// Display-side consumer: FIFO reader, pixel pair split and line marker decode
`timescale 1ns/1ps

module vgafbScanout
    import vgafbPixelPkg::*;
(
    input  logic     RClk,
    input  logic     PresetEmpty,
    // Display enable, low stalls the stream
    input  logic     pixEn,
    // FIFO read port
    input  fifoWordT rdWord,
    input  logic     empty,
    output logic     rdEn,
    // Registered pixel and line events
    output pixOutT   pixOut
);

    logic                    half;
    logic                    fire;
    logic                    isMark;
    rgb565T                  pixNext;
    logic                    pixValidQ;
    logic                    lineEndQ;
    rgb565T                  pixQ;
    logic [lineNumWidth-1:0] lineNumQ;

    // ======================================================================
    // Word decode
    // ======================================================================
    // Something to emit this cycle
    assign fire   = pixEn & ~empty;
    // Same bit in both union views
    assign isMark = rdWord.pixels.isMarker;

    // Second pixel of a pair is the base pixel inverted
    assign pixNext = rgb565T'(rdWord.pixels.pix ^ {$bits(rgb565T){half}});

    // Pop after the second pixel, or right away for a marker
    assign rdEn = fire & (isMark | half);

    // ======================================================================
    // Output registers
    // ======================================================================
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            half      <= 1'b0;
            pixValidQ <= 1'b0;
            lineEndQ  <= 1'b0;
        end else begin
            pixValidQ <= fire & ~isMark;
            lineEndQ  <= fire & isMark;
            // Held while pixEn is low, resumes mid-pair
            if (fire && !isMark) begin
                half <= ~half;
            end
        end
    end

    // Payload, qualified by the valid bits
    always_ff @(posedge RClk) begin
        if (fire && !isMark) begin
            pixQ <= pixNext;
        end
        if (fire && isMark) begin
            lineNumQ <= rdWord.marker.lineNum;
        end
    end

    assign pixOut = '{pixValid: pixValidQ, pix: pixQ, lineEnd: lineEndQ, lineNum: lineNumQ};

    // Pixel and line events are exclusive at the output
    assert property (@(posedge RClk) disable iff (PresetEmpty)
        !(pixOut.pixValid && pixOut.lineEnd))
        else $error("pixValid and lineEnd high together");

endmodule

//--- rtl/vgafbPixelPath.sv
// Pixel path top: fetch, dual-clock FIFO and scanout instances
`timescale 1ns/1ps

module vgafbPixelPath
    import vgafbPixelPkg::*;
(
    input  logic   WClk,
    input  logic   RClk,
    input  logic   PresetEmpty,
    // Memory side, WClk domain
    input  srcReqT src,
    output logic   srcAck,
    // Display side, RClk domain
    input  logic   pixEn,
    output pixOutT pixOut
);

    // Write side nets
    logic     wrEn;
    fifoWordT wrWord;
    logic     full;
    // Read side nets
    logic     rdEn;
    fifoWordT rdWord;
    logic     empty;

    // ======================================================================
    // Memory side
    // ======================================================================
    vgafbFetch i_vgafbFetch (
        .WClk        (WClk),
        .PresetEmpty (PresetEmpty),
        .src         (src),
        .srcAck      (srcAck),
        .wrEn        (wrEn),
        .wrWord      (wrWord),
        .full        (full)
    );

    // Clock boundary
    vgafbAsFifo i_vgafbAsFifo (
        .WClk        (WClk),
        .RClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .wrEn        (wrEn),
        .wrWord      (wrWord),
        .full        (full),
        .rdEn        (rdEn),
        .rdWord      (rdWord),
        .empty       (empty)
    );

    // ======================================================================
    // Display side
    // ======================================================================
    vgafbScanout i_vgafbScanout (
        .RClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .pixEn       (pixEn),
        .rdWord      (rdWord),
        .empty       (empty),
        .rdEn        (rdEn),
        .pixOut      (pixOut)
    );

endmodule

//--- bench/vgafbPixelPathTb.sv
// Pixel path testbench: clocks, reset, stimulus table, LFSR, checker, monitor, watchdog
`timescale 1ns/1ps

module vgafbPixelPathTb
    import vgafbFifoPkg::*, vgafbPixelPkg::*;
();

    localparam int numEntries      = 40;
    localparam int wPeriodNs       = 100;
    localparam int rPeriodNs       = 70;
    localparam int forcedLowCycles = 200;
    // Handshakes, forced display stall, random stalls, margin
    localparam int timeoutNs = numEntries * 12 * wPeriodNs + forcedLowCycles * rPeriodNs
                             + numEntries * 7 * rPeriodNs + 20000;

    // Stimulus word and the output it must produce
    typedef struct packed {
        fifoWordT                word;
        logic                    isMarker;
        rgb565T                  firstPix;
        rgb565T                  secondPix;
        logic [lineNumWidth-1:0] lineNum;
    } stimRowT;

    typedef struct packed {
        logic                    lineEnd;
        rgb565T                  pix;
        logic [lineNumWidth-1:0] lineNum;
    } outEventT;

    logic        WClk;
    logic        RClk;
    logic        PresetEmpty;
    srcReqT      src;
    logic        srcAck;
    logic        pixEn;
    pixOutT      pixOut;
    stimRowT     stimTable [numEntries];
    outEventT    expectQ [$];
    outEventT    expEvent;
    logic [31:0] gapLfsr       = 32'h5273;
    logic [31:0] enLfsr        = 32'h5273;
    logic        enAtEdge      = 1'b0;
    logic        sendDone      = 1'b0;
    int          acceptedCount = 0;
    int          stallCount    = 0;
    int          eventsSeen    = 0;
    int          expectedTotal = 0;

    always #(wPeriodNs / 2) WClk = ~WClk;
    always #(rPeriodNs / 2) RClk = ~RClk;

    vgafbPixelPath i_vgafbPixelPath (
        .WClk        (WClk),
        .RClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .src         (src),
        .srcAck      (srcAck),
        .pixEn       (pixEn),
        .pixOut      (pixOut)
    );

    // ======================================================================
    // Helpers
    // ======================================================================
    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Check %s failed", testName);
        end
    endtask

    task automatic checkOutputsIdle(input string phase);
        compareValue({phase, " srcAck"}, 32'(0), 32'(srcAck));
        compareValue({phase, " pixValid"}, 32'(0), 32'(pixOut.pixValid));
        compareValue({phase, " lineEnd"}, 32'(0), 32'(pixOut.lineEnd));
    endtask

    // Every 7th entry a marker, the rest pixel words
    // A pixel word gives pix then pix inverted, a marker one line end
    task automatic buildTable();
        outEventT ev;
        for (int i = 0; i < numEntries; i++) begin
            stimTable[i] = '0;
            stimTable[i].isMarker = (i % 7 == 6);
            if (stimTable[i].isMarker) begin
                stimTable[i].lineNum                 = lineNumWidth'(i / 7 + 'h100);
                stimTable[i].word.marker.isMarker    = 1'b1;
                stimTable[i].word.marker.lineNum     = stimTable[i].lineNum;
                ev = '{lineEnd: 1'b1, pix: '0, lineNum: stimTable[i].lineNum};
                expectQ.push_back(ev);
            end else begin
                stimTable[i].firstPix  = rgb565T'(16'(i * 'h2F1B + 'h1234));
                stimTable[i].secondPix = rgb565T'(~stimTable[i].firstPix);
                stimTable[i].word.pixels.pix = stimTable[i].firstPix;
                ev = '{lineEnd: 1'b0, pix: stimTable[i].firstPix, lineNum: '0};
                expectQ.push_back(ev);
                ev.pix = stimTable[i].secondPix;
                expectQ.push_back(ev);
            end
        end
        expectedTotal = expectQ.size();
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    // Four-phase handshake per table row, random idle gap first
    task automatic sendEntries();
        logic [1:0] gap;
        int         waited;
        for (int i = 0; i < numEntries; i++) begin
            gap = '0;
            for (int b = 0; b < 2; b++) begin
                gapLfsr = lfsrStep(gapLfsr);
                gap     = {gap[0], gapLfsr[0]};
            end
            repeat (gap) @(negedge WClk);
            src.word = stimTable[i].word;
            src.req  = 1'b1;
            waited   = 0;
            do begin
                @(negedge WClk);
                waited++;
                // Ack held back, FIFO must be full
                if (waited == 5) begin
                    stallCount++;
                    $display("Source stalled by full FIFO at entry %0d", i);
                end
            end while (!srcAck);
            acceptedCount++;
            src.req = 1'b0;
            do @(negedge WClk); while (srcAck);
        end
        sendDone = 1'b1;
    endtask

    task automatic driveDisplayEnable();
        logic [2:0] lowLen;
        // Long stall first, fills the FIFO and holds the source off
        @(negedge RClk);
        pixEn = 1'b0;
        repeat (forcedLowCycles) @(negedge RClk);
        compareValue("words taken in display stall", 32'(fifoDepth), 32'(acceptedCount));
        compareValue("source stall seen", 32'(1), 32'(stallCount > 0));
        while (!sendDone) begin
            pixEn = 1'b1;
            repeat (6) @(negedge RClk);
            lowLen = '0;
            for (int b = 0; b < 3; b++) begin
                enLfsr = lfsrStep(enLfsr);
                lowLen = {lowLen[1:0], enLfsr[0]};
            end
            pixEn = 1'b0;
            repeat (lowLen) @(negedge RClk);
        end
        pixEn = 1'b1;
    endtask

    // ======================================================================
    // Output monitor
    // ======================================================================
    // pixEn as the scanout registers saw it
    always @(posedge RClk) begin
        enAtEdge <= pixEn;
    end

    always @(negedge RClk) begin
        if (!PresetEmpty) begin
            compareValue("pixValid with lineEnd", 32'(0),
                         32'(pixOut.pixValid & pixOut.lineEnd));
            if (!enAtEdge) begin
                compareValue("pixValid while gated", 32'(0), 32'(pixOut.pixValid));
                compareValue("lineEnd while gated", 32'(0), 32'(pixOut.lineEnd));
            end
            if (pixOut.pixValid || pixOut.lineEnd) begin
                if (expectQ.size() == 0) begin
                    $display("Output event after the whole table was drained");
                    $display("** FAIL **");
                    $fatal(1, "Unexpected output event on the display side");
                end else begin
                    expEvent = expectQ.pop_front();
                    compareValue("event kind", 32'(expEvent.lineEnd), 32'(pixOut.lineEnd));
                    if (expEvent.lineEnd) begin
                        compareValue("line number", 32'(expEvent.lineNum),
                                     32'(pixOut.lineNum));
                    end else begin
                        compareValue("pixel", 32'(expEvent.pix), 32'(pixOut.pix));
                    end
                    eventsSeen++;
                end
            end
        end
    end

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        WClk        = 1'b0;
        RClk        = 1'b0;
        PresetEmpty = 1'b1;
        src         = '0;
        pixEn       = 1'b0;
        buildTable();
        repeat (10) begin
            @(negedge WClk);
            checkOutputsIdle("during reset");
        end
        PresetEmpty = 1'b0;
        @(negedge WClk);
        checkOutputsIdle("after reset");
        fork
            sendEntries();
            driveDisplayEnable();
        join
        wait (eventsSeen == expectedTotal);
        // Quiet tail, any late event trips the monitor
        repeat (30) @(negedge RClk);
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("** FAIL **");
        $fatal(1, "Watchdog timeout after %0d ns, the stream did not drain", timeoutNs);
    end

endmodule

//--- tb.f
rtl/vgafbFifoPkg.sv
rtl/vgafbPixelPkg.sv
rtl/vgafbGrayCounter.sv
rtl/vgafbAsFifo.sv
rtl/vgafbFetch.sv
rtl/vgafbScanout.sv
rtl/vgafbPixelPath.sv
bench/vgafbPixelPathTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pixel path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module vgafbPixelPathTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/VvgafbPixelPathTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
